// ==== build.f ====
hw/cpuPkg.sv
hw/instructionSequencer.sv
hw/programCounter.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/memoryPort.sv
hw/cpuCore.sv
test/cpuCoreTb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing -j 0
LINTFLAGS := --lint-only --timing
TOP       := cpuCoreTb
RTLTOP    := cpuCore
FILELIST  := build.f
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/cpuCoreTb.sv ====
`timescale 1ns/1ps

module cpuCoreTb;

	logic CLK;
	logic reset;
	logic [cpuPkg::instWidth-1:0] inst;
	logic ack;
	logic [cpuPkg::dataWidth-1:0] rdata;
	logic [cpuPkg::addrWidth-1:0] instAddr;
	cpuPkg::memReqT memBus;
	logic req;

	logic [cpuPkg::instWidth-1:0] prog [256]; // Program table, one instruction per row
	logic [cpuPkg::dataWidth-1:0] expAddr [$]; // Expected stores in program order
	logic [cpuPkg::dataWidth-1:0] expData [$];
	logic [cpuPkg::dataWidth-1:0] dataMem [256];
	logic [3:0] condList [7];
	logic [cpuPkg::instWidth-1:0] cmpInst [3];
	logic [0:6] takenMask [3]; // Index 0 is BEQ, in the order of condList
	logic [3:0] cmpReg [3];
	logic [cpuPkg::dataWidth-1:0] cmpVal [3];
	int progLen;
	int haltAddr;
	int errors;
	int storeIdx;
	int haltCycles;
	int delayCnt;
	int testsPassed;
	int testsFailed;
	int seedDummy;
	bit randomAck; // Random ack delays in the second run
	logic prevReq;
	logic prevAck;
	cpuPkg::memReqT prevBus;

	cpuCore DUT (.CLK, .reset, .inst, .ack, .rdata, .instAddr, .memBus, .req);

	// Addresses past the table read as JUC to r0
	assign inst = (int'(instAddr) < progLen) ? prog[instAddr[7:0]]
		: memInst(cpuPkg::JCOND, 0, cpuPkg::JUC);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [17:0] immInst(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
		return {2'b00, op, rd, imm};
	endfunction

	function automatic logic [17:0] regInst(logic [3:0] ext, logic [3:0] rd, logic [3:0] rs);
		return {2'b00, cpuPkg::opReg, rd, ext, rs};
	endfunction

	function automatic logic [17:0] memInst(logic [3:0] ext, logic [3:0] rd, logic [3:0] rs);
		return {2'b00, cpuPkg::opMem, rd, ext, rs};
	endfunction

	task automatic emit(input logic [17:0] word);
		prog[progLen] = word;
		progLen++;
	endtask

	task automatic emitStore(input logic [17:0] word, input logic [15:0] a, input logic [15:0] d);
		emit(word);
		expAddr.push_back(a);
		expData.push_back(d);
	endtask

	//////////////////////////////
	// Program and expected stores
	//////////////////////////////
	task automatic buildProgram();
		int base;
		progLen = 0;
		expAddr.delete();
		expData.delete();
		emit(immInst(cpuPkg::opMovi, 1, 8'h12));
		emit(immInst(cpuPkg::opMovi, 15, 8'h40)); // r15 is the store address register
		emitStore(memInst(cpuPkg::STOR, 1, 15), 16'h0040, 16'h0012);
		emit(immInst(cpuPkg::opAddi, 1, 8'h30));
		emitStore(memInst(cpuPkg::STOR, 1, 15), 16'h0040, 16'h0042);
		emit(immInst(cpuPkg::opSubi, 1, 8'h02));
		emit(immInst(cpuPkg::opMovi, 2, 8'h0F));
		emit(regInst(cpuPkg::ADD, 1, 2));
		emitStore(memInst(cpuPkg::STOR, 1, 15), 16'h0040, 16'h004F);
		emit(regInst(cpuPkg::SUB, 1, 2));
		emitStore(memInst(cpuPkg::STOR, 1, 15), 16'h0040, 16'h0040);
		emit(immInst(cpuPkg::opMovi, 3, 8'hC3));
		emit(regInst(cpuPkg::AND, 3, 2));
		emitStore(memInst(cpuPkg::STOR, 3, 15), 16'h0040, 16'h0003);
		emit(regInst(cpuPkg::OR, 3, 1));
		emitStore(memInst(cpuPkg::STOR, 3, 15), 16'h0040, 16'h0043);
		emit(regInst(cpuPkg::XOR, 3, 2));
		emitStore(memInst(cpuPkg::STOR, 3, 15), 16'h0040, 16'h004C);
		emit(regInst(cpuPkg::MOV, 4, 3));
		emitStore(memInst(cpuPkg::STOR, 4, 15), 16'h0040, 16'h004C);
		// Loads read the preload pattern {addr, ~addr}
		emit(immInst(cpuPkg::opMovi, 5, 8'h10));
		emit(memInst(cpuPkg::LOAD, 6, 5));
		emit(immInst(cpuPkg::opAddi, 6, 8'h01));
		emitStore(memInst(cpuPkg::STOR, 6, 5), 16'h0010, 16'h10F0);
		emit(immInst(cpuPkg::opMovi, 5, 8'h20));
		emit(memInst(cpuPkg::LOAD, 6, 5));
		emit(immInst(cpuPkg::opAddi, 6, 8'h05));
		emitStore(memInst(cpuPkg::STOR, 6, 5), 16'h0020, 16'h20E4);
		emit(immInst(cpuPkg::opMovi, 14, 8'h77)); // Marker value
		for (int g = 0; g < 3; g++) begin
			base = progLen;
			// Target skips one marker
			for (int i = 0; i < 7; i++)
				emit(immInst(cpuPkg::opMovi, 4'(7 + i), 8'(base + 10 + 2 * i)));
			emit(cmpInst[g]);
			for (int i = 0; i < 7; i++) begin
				emit(memInst(cpuPkg::JCOND, 4'(7 + i), condList[i]));
				if (takenMask[g][i])
					emit(memInst(cpuPkg::STOR, 14, 15)); // Skipped
				else
					emitStore(memInst(cpuPkg::STOR, 14, 15), 16'h0040, 16'h0077);
			end
			emitStore(memInst(cpuPkg::STOR, cmpReg[g], 15), 16'h0040, cmpVal[g]); // Compare wrote nothing
		end
		emit(immInst(cpuPkg::opMovi, 0, 8'(progLen + 1)));
		haltAddr = progLen;
		emit(memInst(cpuPkg::JCOND, 0, cpuPkg::JUC)); // Jumps to itself
	endtask

	//////////////////////////////
	// Data memory model
	//////////////////////////////
	always @(posedge CLK) begin
		#5;
		if (reset) begin
			ack = 1'b0;
			delayCnt = randomAck ? $urandom % 8 : 0;
		end else if (req && !ack) begin
			if (delayCnt == 0) begin
				ack = 1'b1;
				if (memBus.write)
					dataMem[memBus.addr[7:0]] = memBus.wdata;
				else
					rdata = dataMem[memBus.addr[7:0]];
			end else begin
				delayCnt--;
			end
		end else if (!req && ack) begin
			ack = 1'b0;
			delayCnt = randomAck ? $urandom % 8 : 0; // Delay of the next transfer
		end
	end

	task automatic checkStore();
		assert (storeIdx < expAddr.size()) else begin
			$display("Unexpected store to %h after the last expected one", memBus.addr);
			errors++;
		end
		if (storeIdx < expAddr.size()) begin
			assert (memBus.addr == expAddr[storeIdx]) else begin
				$display("MISMATCH memBus.addr store %0d: got %h expected %h", storeIdx,
					memBus.addr, expAddr[storeIdx]);
				errors++;
			end
			assert (memBus.wdata == expData[storeIdx]) else begin
				$display("MISMATCH memBus.wdata store %0d: got %h expected %h", storeIdx,
					memBus.wdata, expData[storeIdx]);
				errors++;
			end
		end
		storeIdx++;
	endtask

	// Sampled at the falling edge where every signal is settled
	always @(negedge CLK) begin
		if (!reset) begin
			if (req && !prevReq && memBus.write)
				checkStore();
			if (prevReq && !req)
				assert (prevAck) else begin
					$display("Request was dropped before the memory acknowledged it");
					errors++;
				end
			if (prevReq || prevAck)
				assert (memBus == prevBus) else begin
					$display("MISMATCH memBus: got %h expected %h", memBus, prevBus);
					errors++;
				end
			if (int'(instAddr) == haltAddr)
				haltCycles++;
		end
		prevReq = req;
		prevAck = ack;
		prevBus = memBus;
	end

	task automatic applyReset();
		@(posedge CLK);
		#5 reset = 1'b1;
		repeat (16) @(posedge CLK);
		#5 reset = 1'b0;
	endtask

	task automatic runProgram(input bit rnd, input string name);
		int cycles;
		int errBefore;
		errBefore = errors;
		for (int a = 0; a < 256; a++)
			dataMem[a] = {a[7:0], ~a[7:0]};
		randomAck = rnd;
		storeIdx = 0;
		applyReset();
		haltCycles = 0;
		cycles = 0;
		while (haltCycles < 9 && cycles < 20000) begin // Three passes through the halt loop
			@(posedge CLK);
			cycles++;
		end
		assert (haltCycles >= 9) else begin
			$display("Timed out waiting for the program to reach its halt loop");
			errors++;
		end
		assert (storeIdx == expAddr.size()) else begin
			$display("MISMATCH storeIdx: got %h expected %h", storeIdx, expAddr.size());
			errors++;
		end
		reportTest(name, errBefore);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errors == errBefore) begin
			testsPassed++;
			$display("Test %s: ok", name);
		end else begin
			testsFailed++;
			$display("Test %s: FAILED", name);
		end
	endtask

	initial begin
		int errBefore;
		seedDummy = $urandom(32'h9774);
		reset = 1'b1;
		ack = 1'b0;
		rdata = '0;
		randomAck = 1'b0;
		errors = 0;
		testsPassed = 0;
		testsFailed = 0;
		progLen = 0;
		haltAddr = -1;
		condList = '{cpuPkg::BEQ, cpuPkg::BNEQ, cpuPkg::BGT, cpuPkg::BLT,
			cpuPkg::BGE, cpuPkg::BLE, cpuPkg::JUC};
		cmpInst[0] = regInst(cpuPkg::CMP, 2, 1); // 0x0F against 0x40 gives low
		cmpInst[1] = immInst(cpuPkg::opCmpi, 1, 8'h40); // Equal
		cmpInst[2] = immInst(cpuPkg::opCmpui, 1, 8'h10); // Greater
		takenMask = '{7'b0101011, 7'b1000111, 7'b0110101};
		cmpReg = '{4'd2, 4'd1, 4'd1};
		cmpVal = '{16'h000F, 16'h0040, 16'h0040};
		buildProgram();

		errBefore = errors;
		applyReset();
		@(negedge CLK);
		assert (instAddr == '0) else begin
			$display("MISMATCH instAddr: got %h expected %h", instAddr, 16'h0);
			errors++;
		end
		assert (!req) else begin
			$display("MISMATCH req: got %h expected %h", req, 1'b0);
			errors++;
		end
		reportTest("reset", errBefore);
		runProgram(1'b0, "program with immediate ack");
		runProgram(1'b1, "program with random ack delays");

		$display("%0d tests passed, %0d tests failed, %0d errors",
			testsPassed, testsFailed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== hw/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore (
	input logic CLK,
	input logic reset,
	input logic [cpuPkg::instWidth-1:0] inst,
	input logic ack,
	input logic [cpuPkg::dataWidth-1:0] rdata,
	output logic [cpuPkg::addrWidth-1:0] instAddr,
	output cpuPkg::memReqT memBus,
	output logic req
);

	//////////////////////////////
	// Control to datapath
	//////////////////////////////
	logic pcInc;
	logic jumpTake;
	logic regWrite;
	logic writeFromMem;
	logic flagsSave;
	logic memStart;
	logic memWrite;
	logic memDone;
	cpuPkg::aluFlagsT flags;

	//////////////////////////////
	// Data
	//////////////////////////////
	logic [cpuPkg::dataWidth-1:0] rdestData;
	logic [cpuPkg::dataWidth-1:0] rsrcData;
	logic [cpuPkg::dataWidth-1:0] result;
	logic [cpuPkg::dataWidth-1:0] loadData;

	instructionSequencer sequencer (
		.CLK, .reset, .inst, .flags, .memDone,
		.pcInc, .jumpTake, .regWrite, .writeFromMem, .flagsSave, .memStart, .memWrite
	);

	// Jump target comes from Rdest since inst[3:0] carries the condition
	programCounter pcUnit (
		.CLK, .reset, .pcInc, .jumpTake, .jumpTarget(rdestData), .instAddr
	);

	registerFile regs (
		.CLK, .reset, .inst, .regWrite, .writeFromMem,
		.aluResult(result), .loadData, .rdestData, .rsrcData
	);

	aluUnit alu (
		.CLK, .reset, .inst, .flagsSave, .rdestData, .rsrcData, .result, .flags
	);

	// Rsrc holds the address and Rdest the store data
	memoryPort memPort (
		.CLK, .reset, .memStart, .memWrite, .addr(rsrcData), .wdata(rdestData),
		.ack, .rdata, .memBus, .req, .memDone, .loadData
	);

endmodule

// ==== hw/memoryPort.sv ====
`timescale 1ns/1ps

module memoryPort (
	input logic CLK,
	input logic reset,
	input logic memStart, // Held high by the sequencer in load1 or stor1
	input logic memWrite,
	input logic [cpuPkg::dataWidth-1:0] addr,
	input logic [cpuPkg::dataWidth-1:0] wdata,
	input logic ack,
	input logic [cpuPkg::dataWidth-1:0] rdata,
	output cpuPkg::memReqT memBus,
	output logic req,
	output logic memDone,
	output logic [cpuPkg::dataWidth-1:0] loadData
);

	// Phases of the four-phase handshake
	typedef enum logic [1:0] {
		portIdle,
		portReq, // Req high, waiting for ack to rise
		portRelease // Req low, waiting for ack to fall
	} portStateE;

	portStateE portState;

	always_ff @(posedge CLK) begin
		if (reset) begin
			portState <= portIdle;
		end else begin
			case (portState)
				portIdle: if (memStart) portState <= portReq;
				portReq: if (ack) portState <= portRelease;
				portRelease: if (!ack) portState <= portIdle;
				default: portState <= portIdle;
			endcase
		end
	end

	// Bus is loaded only from idle so it stays put while req or ack is high
	always_ff @(posedge CLK) begin
		if (portState == portIdle && memStart)
			memBus <= '{write: memWrite, addr: addr, wdata: wdata};
		if (portState == portReq && ack)
			loadData <= rdata; // Read data is valid while ack is high
	end

	assign req = (portState == portReq);
	assign memDone = (portState == portReq && ack) || (portState == portRelease && !ack);

endmodule

// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input logic CLK,
	input logic reset,
	input logic [cpuPkg::instWidth-1:0] inst,
	input logic flagsSave,
	input logic [cpuPkg::dataWidth-1:0] rdestData,
	input logic [cpuPkg::dataWidth-1:0] rsrcData,
	output logic [cpuPkg::dataWidth-1:0] result,
	output cpuPkg::aluFlagsT flags // Saved flags read by the sequencer
);

	cpuPkg::opcodeE opcode;
	cpuPkg::regExtE regExt;
	cpuPkg::aluFlagsT newFlags;
	logic [cpuPkg::dataWidth-1:0] operand;
	logic [cpuPkg::dataWidth:0] sum; // One extra bit for the carry
	logic [cpuPkg::dataWidth:0] diff; // One extra bit for the borrow
	logic isAdd;
	logic isSub; // Subtracts and compares

	assign opcode = cpuPkg::opcodeE'(inst[15:12]);
	assign regExt = cpuPkg::regExtE'(inst[7:4]);

	// Immediate is zero extended
	assign operand = (opcode == cpuPkg::opReg) ? rsrcData
		: {{(cpuPkg::dataWidth - 8){1'b0}}, inst[7:0]};

	assign sum = {1'b0, rdestData} + {1'b0, operand};
	assign diff = {1'b0, rdestData} - {1'b0, operand};

	////////////////////////////////
	// Result
	////////////////////////////////
	always_comb begin
		result = '0;
		isAdd = 1'b0;
		isSub = 1'b0;
		case (opcode)
			cpuPkg::opReg: begin
				case (regExt)
					cpuPkg::ADD: begin
						result = sum[cpuPkg::dataWidth-1:0];
						isAdd = 1'b1;
					end
					cpuPkg::SUB, cpuPkg::CMP: begin
						result = diff[cpuPkg::dataWidth-1:0];
						isSub = 1'b1;
					end
					cpuPkg::AND: result = rdestData & operand;
					cpuPkg::OR: result = rdestData | operand;
					cpuPkg::XOR: result = rdestData ^ operand;
					cpuPkg::MOV: result = operand;
					default: result = '0;
				endcase
			end
			cpuPkg::opAddi: begin
				result = sum[cpuPkg::dataWidth-1:0];
				isAdd = 1'b1;
			end
			cpuPkg::opSubi, cpuPkg::opCmpi, cpuPkg::opCmpui: begin
				result = diff[cpuPkg::dataWidth-1:0]; // CMPI and CMPUI match with a zero extended immediate
				isSub = 1'b1;
			end
			cpuPkg::opMovi: result = operand;
			default: result = '0;
		endcase
	end

	////////////////////////////////
	// Flags
	////////////////////////////////
	always_comb begin
		newFlags.carry = 1'b0;
		newFlags.overflow = 1'b0;
		if (isAdd) begin
			newFlags.carry = sum[cpuPkg::dataWidth];
			// Like signs in and a different sign out
			newFlags.overflow = (rdestData[cpuPkg::dataWidth-1] == operand[cpuPkg::dataWidth-1])
				&& (sum[cpuPkg::dataWidth-1] != rdestData[cpuPkg::dataWidth-1]);
		end else if (isSub) begin
			newFlags.carry = diff[cpuPkg::dataWidth]; // Borrow
			newFlags.overflow = (rdestData[cpuPkg::dataWidth-1] != operand[cpuPkg::dataWidth-1])
				&& (diff[cpuPkg::dataWidth-1] != rdestData[cpuPkg::dataWidth-1]);
		end
		newFlags.low = rdestData < operand;
		newFlags.negative = $signed(rdestData) < $signed(operand);
		newFlags.zero = (result == '0); // For subtracts and compares this is Rdest equal to operand
	end

	always_ff @(posedge CLK) begin
		if (reset)
			flags <= '0;
		else if (flagsSave)
			flags <= newFlags; // Only ALU instructions get here
	end

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic CLK,
	input logic reset,
	input logic [cpuPkg::instWidth-1:0] inst,
	input logic regWrite,
	input logic writeFromMem, // Selects the load data over the ALU result
	input logic [cpuPkg::dataWidth-1:0] aluResult,
	input logic [cpuPkg::dataWidth-1:0] loadData,
	output logic [cpuPkg::dataWidth-1:0] rdestData,
	output logic [cpuPkg::dataWidth-1:0] rsrcData
);

	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];
	logic [$clog2(cpuPkg::regCount)-1:0] rdestSel;
	logic [$clog2(cpuPkg::regCount)-1:0] rsrcSel;

	assign rdestSel = inst[11:8];
	assign rsrcSel = inst[3:0];

	// Two asynchronous read ports
	assign rdestData = regs[rdestSel];
	assign rsrcData = regs[rsrcSel];

	// Programs rely on every register starting at zero
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < cpuPkg::regCount; i++)
				regs[i] <= '0;
		end else if (regWrite) begin
			regs[rdestSel] <= writeFromMem ? loadData : aluResult;
		end
	end

endmodule

// ==== hw/programCounter.sv ====
`timescale 1ns/1ps

module programCounter (
	input logic CLK,
	input logic reset,
	input logic pcInc,
	input logic jumpTake,
	input logic [cpuPkg::addrWidth-1:0] jumpTarget, // Rdest contents
	output logic [cpuPkg::addrWidth-1:0] instAddr
);

	logic [cpuPkg::addrWidth-1:0] pc;

	// A taken jump wins over the increment
	always_ff @(posedge CLK) begin
		if (reset)
			pc <= '0;
		else if (jumpTake)
			pc <= jumpTarget;
		else if (pcInc)
			pc <= pc + 1'b1; // Wraps at the top of the address space
	end

	assign instAddr = pc; // Instruction memory is read combinationally from here

endmodule

// ==== hw/instructionSequencer.sv ====
`timescale 1ns/1ps

module instructionSequencer (
	input logic CLK,
	input logic reset,
	input logic [cpuPkg::instWidth-1:0] inst,
	input cpuPkg::aluFlagsT flags, // Flags saved by the last ALU instruction
	input logic memDone, // Ends each of the two handshake waits
	output logic pcInc,
	output logic jumpTake,
	output logic regWrite,
	output logic writeFromMem,
	output logic flagsSave,
	output logic memStart,
	output logic memWrite
);

	cpuPkg::seqStateE presentState;
	cpuPkg::seqStateE nextState;
	cpuPkg::opcodeE opcode;
	cpuPkg::regExtE regExt;
	cpuPkg::memExtE memExt;
	cpuPkg::condE cond;
	logic condMet; // Jump condition holds on the saved flags

	assign opcode = cpuPkg::opcodeE'(inst[15:12]);
	assign regExt = cpuPkg::regExtE'(inst[7:4]);
	assign memExt = cpuPkg::memExtE'(inst[7:4]);
	assign cond = cpuPkg::condE'(inst[3:0]);

	always_ff @(posedge CLK) begin
		if (reset)
			presentState <= cpuPkg::fetch;
		else
			presentState <= nextState;
	end

	// Unsigned conditions from L and Z only
	always_comb begin
		case (cond)
			cpuPkg::BEQ: condMet = flags.zero;
			cpuPkg::BNEQ: condMet = !flags.zero;
			cpuPkg::BGT: condMet = !flags.low && !flags.zero;
			cpuPkg::BLT: condMet = flags.low;
			cpuPkg::BGE: condMet = !flags.low;
			cpuPkg::BLE: condMet = flags.low || flags.zero;
			cpuPkg::JUC: condMet = 1'b1;
			default: condMet = 1'b0; // Unknown codes fall through to the next instruction
		endcase
	end

	////////////////////////////////
	// Next state
	////////////////////////////////
	always_comb begin
		nextState = presentState;
		case (presentState)
			cpuPkg::fetch: nextState = cpuPkg::decode; // Instruction memory answers within the cycle
			cpuPkg::decode: begin
				if (opcode == cpuPkg::opMem) begin
					case (memExt)
						cpuPkg::LOAD: nextState = cpuPkg::load1;
						cpuPkg::STOR: nextState = cpuPkg::stor1;
						cpuPkg::JCOND: nextState = cpuPkg::jump;
						default: nextState = cpuPkg::alu; // Runs as a no-op
					endcase
				end else begin
					nextState = cpuPkg::alu;
				end
			end
			cpuPkg::load1: if (memDone) nextState = cpuPkg::load2; // Ack seen high
			cpuPkg::load2: if (memDone) nextState = cpuPkg::fetch; // Ack seen low
			cpuPkg::stor1: if (memDone) nextState = cpuPkg::stor2;
			cpuPkg::stor2: if (memDone) nextState = cpuPkg::fetch;
			default: nextState = cpuPkg::fetch; // The alu and jump states last one cycle
		endcase
	end

	////////////////////////////////
	// Datapath enables
	////////////////////////////////
	always_comb begin
		pcInc = 1'b0;
		jumpTake = 1'b0;
		regWrite = 1'b0;
		writeFromMem = 1'b0;
		flagsSave = 1'b0;
		memStart = 1'b0;
		memWrite = 1'b0;
		case (presentState)
			cpuPkg::alu: begin
				pcInc = 1'b1;
				case (opcode)
					cpuPkg::opReg: begin
						case (regExt)
							cpuPkg::CMP: flagsSave = 1'b1; // Compare leaves the registers alone
							cpuPkg::ADD, cpuPkg::SUB, cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR,
							cpuPkg::MOV: begin
								flagsSave = 1'b1;
								regWrite = 1'b1;
							end
							default: ;
						endcase
					end
					cpuPkg::opAddi, cpuPkg::opSubi, cpuPkg::opMovi: begin
						flagsSave = 1'b1;
						regWrite = 1'b1;
					end
					cpuPkg::opCmpi, cpuPkg::opCmpui: flagsSave = 1'b1;
					default: ; // Unknown opcodes only advance the PC
				endcase
			end
			cpuPkg::load1: memStart = 1'b1;
			cpuPkg::load2: begin
				writeFromMem = 1'b1;
				regWrite = memDone; // Load data lands on the edge that leaves load2
				pcInc = memDone;
			end
			cpuPkg::stor1: begin
				memStart = 1'b1;
				memWrite = 1'b1;
			end
			cpuPkg::stor2: pcInc = memDone;
			cpuPkg::jump: begin
				jumpTake = condMet;
				pcInc = !condMet;
			end
			default: ;
		endcase
	end

endmodule

// ==== hw/cpuPkg.sv ====
package cpuPkg;

	////////////////////////////////
	// Widths
	////////////////////////////////
	localparam int dataWidth = 16; // Register and data memory word
	localparam int instWidth = 18; // Instruction word, bits 17:16 are reserved
	localparam int addrWidth = 16; // PC and data address
	localparam int regCount = 16; // Number of general registers

	// Instruction fields
	// Rdest is inst[11:8], also the jump target register
	// Rsrc is inst[3:0], also the load and store address register
	// The immediate is inst[7:0], zero extended to dataWidth
	// The jump condition shares inst[3:0] with Rsrc

	////////////////////////////////
	// Encodings
	////////////////////////////////
	typedef enum logic [3:0] {
		opReg = 4'b0000, // Register to register, extension in inst[7:4]
		opMem = 4'b0100, // Load, store and jump, extension in inst[7:4]
		opAddi = 4'b0101,
		opSubi = 4'b1001,
		opCmpi = 4'b1011,
		opMovi = 4'b1101,
		opCmpui = 4'b1110
	} opcodeE;

	typedef enum logic [3:0] {
		AND = 4'b0001,
		OR = 4'b0010,
		XOR = 4'b0011,
		ADD = 4'b0101,
		SUB = 4'b1001,
		CMP = 4'b1011, // Sets flags and writes no register
		MOV = 4'b1101
	} regExtE;

	typedef enum logic [3:0] {
		LOAD = 4'b0000,
		STOR = 4'b0100,
		JCOND = 4'b1100 // Absolute jump to the address held in Rdest
	} memExtE;

	// All conditions are unsigned and read only the L and Z flags
	typedef enum logic [3:0] {
		BEQ = 4'b0000,
		BNEQ = 4'b0001,
		BGT = 4'b0110,
		BLT = 4'b0111,
		BLE = 4'b1100,
		BGE = 4'b1101,
		JUC = 4'b1110
	} condE;

	typedef enum logic [2:0] {
		fetch,
		decode,
		alu,
		load1,
		load2,
		stor1,
		stor2,
		jump
	} seqStateE;

	////////////////////////////////
	// Bundles
	////////////////////////////////
	typedef struct packed {
		logic carry; // C, carry out of add or borrow of subtract
		logic low; // L, unsigned Rdest below operand
		logic overflow; // F, signed overflow
		logic zero; // Z
		logic negative; // N, signed Rdest below operand
	} aluFlagsT;

	typedef struct packed {
		logic write; // High for a store
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
	} memReqT;

endpackage
